/* design/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

   localparam int word_w = 32;      // datapath width

   // opcodes seen by the fetch side
   localparam logic [5:0] op_special = 6'h00;   // R-format, funct selects op
   localparam logic [5:0] op_j       = 6'h02;   // absolute jump
   localparam logic [5:0] op_bgt     = 6'h07;   // branch if rs > rt, unsigned

   // function codes under op_special
   localparam logic [5:0] fn_jr = 6'h08;        // jump register

   // one instruction word, three ways to read it
   typedef union packed {
      struct packed {
         logic [5:0] opcode;
         logic [4:0] rs;
         logic [4:0] rt;
         logic [4:0] rd;
         logic [4:0] shamt;
         logic [5:0] funct;
      } r_fmt;
      struct packed {
         logic [5:0]  opcode;
         logic [4:0]  rs;
         logic [4:0]  rt;
         logic [15:0] imm;           // branch target for bgt
      } i_fmt;
      struct packed {
         logic [5:0]  opcode;
         logic [25:0] target;
      } j_fmt;
   } instr_u;

endpackage

`default_nettype wire

/* design/instruction_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module instruction_memory import cpu_pkg::*; #(
   parameter int addr_w    = 7,
   parameter int mem_depth = 128
) (
   input  wire logic              clk,
   input  wire logic              reset,        // async, active low
   input  wire logic              we,
   input  wire logic [addr_w-1:0] write_addr,
   input  wire logic [word_w-1:0] write_data,
   input  wire logic [addr_w-1:0] read_addr,
   output logic      [word_w-1:0] read_data
);

   logic [word_w-1:0] mem [mem_depth];

   // program store
   // reset wipes every word, so a fresh run needs a reload
   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         for (int i = 0; i < mem_depth; i++) begin
            mem[i] <= '0;
         end
      end
      else if (we) begin
         mem[write_addr] <= write_data;   // one-cycle write
      end
   end

   // fetch read is combinational, same cycle as pc
   assign read_data = mem[read_addr];

endmodule

`default_nettype wire

/* design/program_control.sv */
`timescale 1ns/1ps
`default_nettype none

module program_control import cpu_pkg::*; #(
   parameter int addr_w    = 7,
   parameter int mem_depth = 128
) (
   input  wire logic              clk,
   input  wire logic              reset,         // async, active low
   input  wire logic              suspend,       // level, high while loading
   input  wire logic              stall,
   input  wire logic              flush,         // j or jr sitting in ID
   input  wire logic              load_en,
   input  wire logic [addr_w-1:0] load_addr,
   input  wire logic [word_w-1:0] load_data,
   input  wire logic              jump,          // any of j, jr, bgt
   input  wire logic              jump_reg,
   input  wire logic              branch,
   input  wire logic [25:0]       jump_target,
   input  wire logic [word_w-1:0] rs_data,
   input  wire logic [word_w-1:0] rt_data,
   input  wire logic [word_w-1:0] fwd_data,      // execute-stage result
   input  wire logic              fwd_sel0,
   input  wire logic              fwd_sel1,
   input  wire logic [word_w-1:0] mem_data,
   output logic      [addr_w-1:0] pc,
   output logic                   mem_we,
   output logic      [word_w-1:0] if_instr,
   output logic                   halted
);

   localparam logic [addr_w-1:0] last_addr = addr_w'(mem_depth - 1);

   logic [word_w-1:0] op0;            // jr target / bgt left side
   logic [word_w-1:0] op1;            // bgt right side
   logic [word_w-1:0] fetch_word;     // memory word with load bypass
   logic [addr_w-1:0] next_pc;
   logic              branch_taken;
   logic              end_of_prog;
   logic              pc_hold;
   logic              suspend_q;      // suspend already seen last cycle

   // operand select, forwarded result beats the register file
   assign op0 = fwd_sel0 ? fwd_data : rs_data;
   assign op1 = fwd_sel1 ? fwd_data : rt_data;

   assign branch_taken = branch && (op0 > op1);   // unsigned compare

   // loads only land while suspended
   assign mem_we = load_en && suspend;

   // a word being written at pc this cycle counts as already there
   assign fetch_word = (mem_we && (load_addr == pc)) ? load_data : mem_data;

   // squash the slot behind a taken control transfer
   always_comb begin
      if (suspend || flush || branch_taken) begin
         if_instr = '0;               // bubble
      end
      else begin
         if_instr = fetch_word;
      end
   end

   // next address
   always_comb begin
      if (jump_reg) begin
         next_pc = op0[addr_w-1:0];   // jr, low bits of rs
      end
      else if (branch) begin
         if (branch_taken) begin
            next_pc = jump_target[addr_w-1:0];
         end
         else begin
            next_pc = pc + addr_w'(1);   // falls through
         end
      end
      else if (jump) begin
         next_pc = jump_target[addr_w-1:0];   // plain j
      end
      else begin
         next_pc = pc + addr_w'(1);
      end
   end

   // last slot or empty word, unless ID is redirecting us
   assign end_of_prog = ((pc == last_addr) || (fetch_word == '0)) && !jump;

   assign pc_hold = stall || (suspend && suspend_q) || end_of_prog;

   // only report the program end, not a load pause
   assign halted = end_of_prog && !suspend;

   // out of reset fetch counts as already suspended,
   // so pc stays put from the very first load cycle
   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         suspend_q <= 1'b1;
      end
      else begin
         suspend_q <= suspend;
      end
   end

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         pc <= '0;
      end
      else if (!pc_hold) begin
         pc <= next_pc;
      end
   end

endmodule

`default_nettype wire

/* design/fetch_decode_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_decode_reg import cpu_pkg::*; (
   input  wire logic              clk,
   input  wire logic              reset,      // async, active low
   input  wire logic              stall,
   input  wire logic              flush,
   input  wire logic [word_w-1:0] if_instr,
   output logic      [word_w-1:0] id_instr
);

   // IF/ID register
   // a zero word is a bubble, decodes to nothing
   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         id_instr <= '0;
      end
      else if (flush) begin
         id_instr <= '0;            // kill slot behind j/jr, wins over stall
      end
      else if (!stall) begin
         id_instr <= if_instr;      // normal advance
      end
      // stall alone keeps the word in ID
   end

endmodule

`default_nettype wire

/* design/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage import cpu_pkg::*; #(
   parameter int addr_w = 7
) (
   input  wire logic              clk,
   input  wire logic              reset,          // async, active low
   input  wire logic [word_w-1:0] id_instr,
   input  wire logic              wb_en,          // write-back port
   input  wire logic [4:0]        wb_addr,
   input  wire logic [word_w-1:0] wb_data,
   input  wire logic              fwd_en,         // execute stage writes a reg
   input  wire logic [4:0]        fwd_dest,
   output logic                   jump,
   output logic                   jump_reg,
   output logic                   branch,
   output logic      [25:0]       jump_target,
   output logic      [word_w-1:0] rs_data,
   output logic      [word_w-1:0] rt_data,
   output logic                   fwd_sel0,
   output logic                   fwd_sel1,
   output logic                   flush
);

   instr_u            instr;
   logic [4:0]        rs;
   logic [4:0]        rt;
   logic              is_j;
   logic              is_jr;
   logic              is_bgt;
   logic [25:0]       raw_target;
   logic [word_w-1:0] regs [32];

   assign instr = id_instr;
   assign rs    = instr.r_fmt.rs;     // same bits in R and I format
   assign rt    = instr.r_fmt.rt;

   // control transfer decode
   assign is_j   = (instr.j_fmt.opcode == op_j);
   assign is_jr  = (instr.r_fmt.opcode == op_special) && (instr.r_fmt.funct == fn_jr);
   assign is_bgt = (instr.i_fmt.opcode == op_bgt);

   assign jump     = is_j || is_jr || is_bgt;
   assign jump_reg = is_jr;
   assign branch   = is_bgt;
   assign flush    = is_j || is_jr;   // unconditional, slot behind is dead

   // bgt outcome is unknown here, fetch squashes on a taken compare

   always_comb begin
      if (is_j) begin
         raw_target = instr.j_fmt.target;
      end
      else if (is_bgt) begin
         raw_target = {10'b0, instr.i_fmt.imm};   // absolute, not pc relative
      end
      else begin
         raw_target = '0;
      end
   end

   // only addr_w bits can address the program store
   assign jump_target = {{(26 - addr_w){1'b0}}, raw_target[addr_w-1:0]};

   // register file, r0 never written
   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end
      else if (wb_en && (wb_addr != 5'd0)) begin
         regs[wb_addr] <= wb_data;
      end
   end

   // reads, r0 hardwired, write-back passes straight through
   always_comb begin
      if (rs == 5'd0) begin
         rs_data = '0;
      end
      else if (wb_en && (wb_addr == rs)) begin
         rs_data = wb_data;
      end
      else begin
         rs_data = regs[rs];
      end
   end

   always_comb begin
      if (rt == 5'd0) begin
         rt_data = '0;
      end
      else if (wb_en && (wb_addr == rt)) begin
         rt_data = wb_data;
      end
      else begin
         rt_data = regs[rt];
      end
   end

   // newer result still in execute overrides the file
   assign fwd_sel0 = fwd_en && (rs != 5'd0) && (fwd_dest == rs);
   assign fwd_sel1 = fwd_en && (rt != 5'd0) && (fwd_dest == rt);

endmodule

`default_nettype wire

/* design/fetch_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_top import cpu_pkg::*; #(
   parameter int addr_w    = 7,
   parameter int mem_depth = 128
) (
   input  wire logic              clk,
   input  wire logic              reset,          // async, active low
   input  wire logic              suspend,        // hold fetch for loading
   input  wire logic              load_en,
   input  wire logic [addr_w-1:0] load_addr,
   input  wire logic [word_w-1:0] load_data,
   input  wire logic              stall,
   input  wire logic              wb_en,
   input  wire logic [4:0]        wb_addr,
   input  wire logic [word_w-1:0] wb_data,
   input  wire logic              fwd_en,
   input  wire logic [4:0]        fwd_dest,
   input  wire logic [word_w-1:0] fwd_data,
   output logic      [addr_w-1:0] pc,
   output logic      [word_w-1:0] id_instr,
   output logic                   halted,
   output logic      [word_w-1:0] rs_data,
   output logic      [word_w-1:0] rt_data
);

   logic              mem_we;
   logic [word_w-1:0] mem_data;
   logic [word_w-1:0] if_instr;
   logic              flush;
   logic              jump;
   logic              jump_reg;
   logic              branch;
   logic [25:0]       jump_target;
   logic              fwd_sel0;
   logic              fwd_sel1;

   // producer, pc and fetch squash
   program_control #(.addr_w(addr_w), .mem_depth(mem_depth)) program_control_inst (
      .clk, .reset, .suspend, .stall, .flush, .load_en, .load_addr, .load_data,
      .jump, .jump_reg, .branch, .jump_target, .rs_data, .rt_data, .fwd_data,
      .fwd_sel0, .fwd_sel1, .mem_data, .pc, .mem_we, .if_instr, .halted
   );

   instruction_memory #(.addr_w(addr_w), .mem_depth(mem_depth)) instruction_memory_inst (
      .clk, .reset, .we(mem_we), .write_addr(load_addr), .write_data(load_data),
      .read_addr(pc), .read_data(mem_data)
   );

   // buffer, IF/ID
   fetch_decode_reg fetch_decode_reg_inst (
      .clk, .reset, .stall, .flush, .if_instr, .id_instr
   );

   // consumer, decode and register file
   decode_stage #(.addr_w(addr_w)) decode_stage_inst (
      .clk, .reset, .id_instr, .wb_en, .wb_addr, .wb_data, .fwd_en, .fwd_dest,
      .jump, .jump_reg, .branch, .jump_target, .rs_data, .rt_data,
      .fwd_sel0, .fwd_sel1, .flush
   );

endmodule

`default_nettype wire

/* testbench/tb_fetch_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_top;

   localparam int addr_w        = 7;
   localparam int mem_depth     = 128;
   localparam int clk_period    = 8;
   localparam int test_cycles   = 450;    // loads, runs and resets of all tests
   localparam int margin_cycles = 150;

   // ISA encodings
   localparam logic [5:0] opc_special = 6'h00;
   localparam logic [5:0] opc_j       = 6'h02;
   localparam logic [5:0] opc_bgt     = 6'h07;
   localparam logic [5:0] fn_jr_code  = 6'h08;

   logic        clk;
   logic        reset;
   logic        suspend;
   logic        load_en;
   logic [6:0]  load_addr;
   logic [31:0] load_data;
   logic        stall;
   logic        wb_en;
   logic [4:0]  wb_addr;
   logic [31:0] wb_data;
   logic        fwd_en;
   logic [4:0]  fwd_dest;
   logic [31:0] fwd_data;
   logic [6:0]  pc;
   logic [31:0] id_instr;
   logic        halted;
   logic [31:0] rs_data;
   logic [31:0] rt_data;

   int error_count = 0;

   // reference model state
   logic [31:0] prog [mem_depth];   // shadow of the program store
   logic [31:0] regs [32];          // shadow register file
   logic [6:0]  m_pc;
   logic [31:0] m_id;
   logic        m_susp_q;
   logic [4:0]  m_rs;
   logic [4:0]  m_rt;
   logic        m_j;
   logic        m_jr;
   logic        m_bgt;
   logic        m_taken;
   logic        m_end;
   logic [31:0] m_a;
   logic [31:0] m_b;
   logic [31:0] m_word;
   logic [31:0] m_if;

   fetch_top #(.addr_w(addr_w), .mem_depth(mem_depth)) fetch_top_inst (
      .clk, .reset, .suspend, .load_en, .load_addr, .load_data, .stall,
      .wb_en, .wb_addr, .wb_data, .fwd_en, .fwd_dest, .fwd_data,
      .pc, .id_instr, .halted, .rs_data, .rt_data
   );

   initial begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   task automatic report_error(input string name, input logic [31:0] got,
                               input logic [31:0] want);
      error_count++;
      $display("error: %s = %h, expected %h", name, got, want);
      $display("Verification failed");
      $fatal(1, "mismatch on %s", name);
   endtask

   task automatic report_failure(input string what);
      error_count++;
      $display("%s", what);
      $display("Verification failed");
      $fatal(1, "run aborted");
   endtask

   initial begin
      #((test_cycles + margin_cycles) * clk_period);
      report_failure("watchdog expired, the run did not finish in time");
   end

   // instruction builders
   function automatic logic [31:0] enc_j(input logic [6:0] target);
      return {opc_j, 19'd0, target};
   endfunction

   function automatic logic [31:0] enc_jr(input logic [4:0] rs);
      return {opc_special, rs, 15'd0, fn_jr_code};
   endfunction

   function automatic logic [31:0] enc_bgt(input logic [4:0] rs, input logic [4:0] rt,
                                           input logic [6:0] target);
      return {opc_bgt, rs, rt, 9'd0, target};
   endfunction

   // opcode >= 0x20, never zero and never a control transfer
   function automatic logic [31:0] random_filler();
      logic [31:0] w;
      w = $urandom;
      w[31] = 1'b1;
      return w;
   endfunction

   // register read, r0 is zero, write-back visible at once
   function automatic logic [31:0] file_value(input logic [4:0] idx);
      if (idx == 5'd0) return 32'd0;
      if (wb_en && (wb_addr == idx)) return wb_data;
      return regs[idx];
   endfunction

   function automatic logic [31:0] operand_value(input logic [4:0] idx);
      if (fwd_en && (idx != 5'd0) && (fwd_dest == idx)) return fwd_data;   // execute result
      return file_value(idx);
   endfunction

   // values before the edge, model steps one cycle
   always @(posedge clk or negedge reset) begin
      if (!reset) begin
         m_pc = '0;
         m_id = '0;
         m_susp_q = 1'b1;                   // fetch frozen out of reset
         for (int i = 0; i < mem_depth; i++) prog[i] = '0;
         for (int i = 0; i < 32; i++) regs[i] = '0;
      end
      else begin
         m_rs    = m_id[25:21];
         m_rt    = m_id[20:16];
         m_j     = (m_id[31:26] == opc_j);
         m_jr    = (m_id[31:26] == opc_special) && (m_id[5:0] == fn_jr_code);
         m_bgt   = (m_id[31:26] == opc_bgt);
         m_a     = operand_value(m_rs);
         m_b     = operand_value(m_rt);
         m_taken = m_bgt && (m_a > m_b);
         m_word  = prog[m_pc];
         m_if    = (suspend || m_j || m_jr || m_taken) ? 32'd0 : m_word;
         m_end   = ((m_pc == 7'd127) || (m_word == 32'd0)) && !(m_j || m_jr || m_bgt);

         assert (pc == m_pc) else report_error("pc", 32'(pc), 32'(m_pc));
         assert (id_instr == m_id) else report_error("id_instr", id_instr, m_id);
         assert (halted == (m_end && !suspend))
            else report_error("halted", 32'(halted), 32'(m_end && !suspend));
         assert (rs_data == file_value(m_rs))
            else report_error("rs_data", rs_data, file_value(m_rs));
         assert (rt_data == file_value(m_rt))
            else report_error("rt_data", rt_data, file_value(m_rt));

         if (!(stall || (suspend && m_susp_q) || m_end)) begin
            if (m_j || m_taken) m_pc = m_id[6:0];   // J target or bgt imm
            else if (m_jr) m_pc = m_a[6:0];
            else m_pc = m_pc + 7'd1;
         end
         if (m_j || m_jr) m_id = '0;                // flush beats stall
         else if (!stall) m_id = m_if;
         if (load_en && suspend) prog[load_addr] = load_data;
         if (wb_en && (wb_addr != 5'd0)) regs[wb_addr] = wb_data;
         m_susp_q = suspend;
      end
   end

   // outputs cleared while reset is held
   always @(posedge clk) begin
      if (!reset) begin
         assert (pc == 7'd0) else report_error("pc", 32'(pc), 32'd0);
         assert (id_instr == 32'd0) else report_error("id_instr", id_instr, 32'd0);
      end
   end

   task automatic load_word(input logic [6:0] addr, input logic [31:0] data);
      @(negedge clk);
      load_en   = 1'b1;
      load_addr = addr;
      load_data = data;
   endtask

   task automatic load_filler(input int first, input int last);
      for (int a = first; a <= last; a++) load_word(7'(a), random_filler());
   endtask

   task automatic write_reg(input logic [4:0] idx, input logic [31:0] data);
      @(negedge clk);
      load_en = 1'b0;
      wb_en   = 1'b1;
      wb_addr = idx;
      wb_data = data;
      @(negedge clk);
      wb_en   = 1'b0;
   endtask

   task automatic wait_pc(input logic [6:0] target, input int limit);
      int n;
      n = 0;
      @(negedge clk);
      while (pc != target) begin
         if (n == limit) report_failure($sformatf("pc never reached %0d", target));
         n++;
         @(negedge clk);
      end
   endtask

   task automatic wait_halted(input int limit);
      int n;
      n = 0;
      @(negedge clk);
      while (!halted) begin
         if (n == limit) report_failure("halted never went high");
         n++;
         @(negedge clk);
      end
   endtask

   initial begin
      logic [31:0] r4_val;
      int unsigned seed_val;
      seed_val  = $urandom(32'h0625c9cd);
      reset     = 1'b1;
      suspend   = 1'b1;
      load_en   = 1'b0;
      load_addr = '0;
      load_data = '0;
      stall     = 1'b0;
      wb_en     = 1'b0;
      wb_addr   = '0;
      wb_data   = '0;
      fwd_en    = 1'b0;
      fwd_dest  = '0;
      fwd_data  = '0;
      #1 reset = 1'b0;                      // clean falling edge for the async reset
      repeat (4) @(posedge clk);
      @(negedge clk);
      reset = 1'b1;

      // program A, suspended load with jumps and branches
      load_filler(0, 9);
      load_word(7'd10, enc_j(7'd20));
      load_filler(11, 24);
      load_word(7'd25, enc_jr(5'd3));       // r3 low bits point at 40
      load_filler(26, 27);
      load_filler(40, 44);
      load_word(7'd45, enc_bgt(5'd4, 5'd7, 7'd60));   // r4 > r7, taken
      load_filler(46, 47);
      load_filler(60, 62);
      load_word(7'd63, enc_bgt(5'd7, 5'd4, 7'd80));   // falls through
      load_filler(64, 66);
      load_word(7'd67, enc_bgt(5'd5, 5'd4, 7'd90));   // only taken via forwarding
      load_filler(68, 69);
      load_filler(90, 99);                  // word 100 stays zero
      r4_val = ($urandom >> 2) + 32'd1;
      write_reg(5'd3, ($urandom & ~32'h7f) | 32'd40);
      write_reg(5'd4, r4_val);
      write_reg(5'd7, r4_val >> 1);

      @(negedge clk);
      suspend  = 1'b0;
      fwd_en   = 1'b1;                      // execute stage about to write r5
      fwd_dest = 5'd5;
      fwd_data = r4_val + 32'd1 + ($urandom & 32'hffff);
      wait_pc(7'd94, 200);
      stall = 1'b1;
      repeat (3) @(negedge clk);
      stall = 1'b0;
      wait_halted(40);
      assert (pc == 7'd100) else report_error("pc", 32'(pc), 32'd100);

      // reset mid-run, store comes back empty
      reset  = 1'b0;
      fwd_en = 1'b0;
      repeat (4) @(negedge clk);
      reset = 1'b1;
      wait_halted(10);
      assert (pc == 7'd0) else report_error("pc", 32'(pc), 32'd0);

      // full store, runs into the last address
      @(negedge clk);
      suspend = 1'b1;
      load_filler(0, mem_depth - 1);
      @(negedge clk);
      load_en = 1'b0;
      suspend = 1'b0;
      wait_halted(mem_depth + 10);
      assert (pc == 7'd127) else report_error("pc", 32'(pc), 32'd127);
      repeat (4) @(negedge clk);            // halt must persist

      if (error_count == 0) begin
         $display("Verification passed");
      end
      else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* build.f */
design/cpu_pkg.sv
design/instruction_memory.sv
design/program_control.sv
design/fetch_decode_reg.sv
design/decode_stage.sv
design/fetch_top.sv
testbench/tb_fetch_top.sv

/* Bender.yml */
package:
  name: fetch_top

sources:
  - files:
      - design/cpu_pkg.sv
      - design/instruction_memory.sv
      - design/program_control.sv
      - design/fetch_decode_reg.sv
      - design/decode_stage.sv
      - design/fetch_top.sv
  - target: simulation
    files:
      - testbench/tb_fetch_top.sv
